// File: cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Byte address and data widths
`define CACHE_ADDR_BITS 32
`define CACHE_DATA_BITS 32

// Address split into tag, set index, word offset and byte offset
`define CACHE_INDEX_BITS 4
`define CACHE_WORD_BITS 2
`define CACHE_BYTE_BITS 2
`define CACHE_TAG_BITS 24

// Field positions inside the byte address
`define CACHE_INDEX_LSB (`CACHE_BYTE_BITS + `CACHE_WORD_BITS)
`define CACHE_TAG_LSB (`CACHE_INDEX_LSB + `CACHE_INDEX_BITS)

// Array depths
`define CACHE_SETS (1 << `CACHE_INDEX_BITS)
`define CACHE_WORDS_PER_BLOCK (1 << `CACHE_WORD_BITS)

`endif

// File: cachePkg.sv
`include "cache_defines.svh"

package cachePkg;

  // One word access from the memory stage
  typedef struct packed {
    logic                        read;
    logic                        write;
    logic [`CACHE_ADDR_BITS-1:0] addr;
    logic [`CACHE_DATA_BITS-1:0] wdata;
  } cpuReq_t;

  // Per-way, per-set tag state
  typedef struct packed {
    logic                       valid;
    logic                       dirty;
    logic [`CACHE_TAG_BITS-1:0] tag;
  } tagEntry_t;

  // Single-word transfer request to the APB master
  typedef struct packed {
    logic                        start;
    logic                        write;
    logic [`CACHE_ADDR_BITS-1:0] addr;
    logic [`CACHE_DATA_BITS-1:0] wdata;
  } busCmd_t;

  typedef enum logic [1:0] {
    Ready,
    WriteBack,
    MemRead
  } ctrlState_t;

  typedef enum logic [1:0] {
    ApbIdle,
    ApbSetup,
    ApbAccess
  } apbState_t;

endpackage

// File: cacheController.sv
`include "cache_defines.svh"

module cacheController (
  input  logic                        clk,
  input  logic                        reset,
  input  cachePkg::cpuReq_t           cpuReq,
  input  logic                        hitWay0,
  input  logic                        hitWay1,
  input  logic                        lruWay,
  input  cachePkg::tagEntry_t         victimEntry,
  input  logic [`CACHE_DATA_BITS-1:0] victimWord,
  input  logic                        busDone,
  output logic                        stall,
  output logic                        wayEn,
  output logic                        tagWe,
  output cachePkg::tagEntry_t         newEntry,
  output logic                        setDirty,
  output logic                        touch,
  output logic                        dataWe,
  output logic                        fillSel,
  output logic [`CACHE_WORD_BITS-1:0] wordIdx,
  output cachePkg::busCmd_t           busCmd
);

  cachePkg::ctrlState_t state;
  cachePkg::ctrlState_t nextState;
  logic [`CACHE_WORD_BITS-1:0] counter;
  logic busBusy;
  logic reqValid;
  logic hit;
  logic inBusState;
  logic lastWord;
  logic [`CACHE_TAG_BITS-1:0] reqTag;
  logic [`CACHE_INDEX_BITS-1:0] reqIndex;
  logic [`CACHE_WORD_BITS-1:0] reqWord;
  logic [`CACHE_TAG_BITS-1:0] busTag;

  assign reqTag   = cpuReq.addr[`CACHE_ADDR_BITS-1:`CACHE_TAG_LSB];
  assign reqIndex = cpuReq.addr[`CACHE_TAG_LSB-1:`CACHE_INDEX_LSB];
  assign reqWord  = cpuReq.addr[`CACHE_INDEX_LSB-1:`CACHE_BYTE_BITS];

  assign reqValid   = cpuReq.read | cpuReq.write;
  assign hit        = hitWay0 | hitWay1;
  assign inBusState = (state == cachePkg::WriteBack) || (state == cachePkg::MemRead);
  assign lastWord   = busDone && (counter == '1);

  // Hit way wins, else the replacement way from the tag array
  always_comb begin
    if (hitWay0) begin
      wayEn = 1'b0;
    end else if (hitWay1) begin
      wayEn = 1'b1;
    end else begin
      wayEn = lruWay;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= cachePkg::Ready;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      cachePkg::Ready: begin
        if (reqValid && !hit) begin
          // Only a valid dirty victim needs writing back
          if (victimEntry.valid && victimEntry.dirty) begin
            nextState = cachePkg::WriteBack;
          end else begin
            nextState = cachePkg::MemRead;
          end
        end
      end
      cachePkg::WriteBack: begin
        if (lastWord) begin
          nextState = cachePkg::MemRead;
        end
      end
      cachePkg::MemRead: begin
        if (lastWord) begin
          nextState = cachePkg::Ready;
        end
      end
      default: nextState = cachePkg::Ready;
    endcase
  end

  // Word counter wraps back to zero on the last transfer of a block
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      counter <= '0;
    end else if (!inBusState) begin
      counter <= '0;
    end else if (busDone) begin
      counter <= lastWord ? '0 : counter + 1'b1;
    end
  end

  // Outstanding APB transfer
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      busBusy <= 1'b0;
    end else if (busCmd.start) begin
      busBusy <= 1'b1;
    end else if (busDone) begin
      busBusy <= 1'b0;
    end
  end

  assign stall = (state != cachePkg::Ready) || (reqValid && !hit);

  // Access completes in Ready on a hit
  assign touch    = (state == cachePkg::Ready) && reqValid && hit;
  assign setDirty = touch && cpuReq.write;

  assign fillSel = (state == cachePkg::MemRead);
  assign dataWe  = (fillSel && busDone) || setDirty;
  assign wordIdx = (state == cachePkg::Ready) ? reqWord : counter;

  // Block becomes valid and clean with the last fill word
  assign tagWe          = fillSel && lastWord;
  assign newEntry.valid = 1'b1;
  assign newEntry.dirty = 1'b0;
  assign newEntry.tag   = reqTag;

  // Write-back goes to the victim's old block address
  assign busTag = (state == cachePkg::WriteBack) ? victimEntry.tag : reqTag;

  assign busCmd.start = inBusState && !busBusy;
  assign busCmd.write = (state == cachePkg::WriteBack);
  assign busCmd.addr  = {busTag, reqIndex, counter, {`CACHE_BYTE_BITS{1'b0}}};
  assign busCmd.wdata = victimWord;

  // Completion only for a transfer this FSM started
  doneOnlyForOwnTransfer: assert property (
    @(posedge clk) disable iff (reset)
    busDone |-> (inBusState && busBusy)
  );

endmodule

// File: cacheTagArray.sv
`include "cache_defines.svh"

module cacheTagArray (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [`CACHE_INDEX_BITS-1:0] index,
  input  logic [`CACHE_TAG_BITS-1:0]   reqTag,
  input  logic                         wayEn,
  input  logic                         tagWe,
  input  cachePkg::tagEntry_t          newEntry,
  input  logic                         setDirty,
  input  logic                         touch,
  output logic                         hitWay0,
  output logic                         hitWay1,
  output logic                         lruWay,
  output cachePkg::tagEntry_t          victimEntry
);

  cachePkg::tagEntry_t ways [2][`CACHE_SETS];
  // Each bit names the least recently used way of its set
  logic [`CACHE_SETS-1:0] lruBits;
  cachePkg::tagEntry_t entry0;
  cachePkg::tagEntry_t entry1;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int s = 0; s < `CACHE_SETS; s++) begin
        ways[0][s] <= '0;
        ways[1][s] <= '0;
        lruBits[s] <= 1'b0;
      end
    end else begin
      if (tagWe) begin
        ways[wayEn][index] <= newEntry;
      end else if (setDirty) begin
        ways[wayEn][index].dirty <= 1'b1;
      end
      // The way just used stops being LRU
      if (touch) begin
        lruBits[index] <= ~wayEn;
      end
    end
  end

  assign entry0 = ways[0][index];
  assign entry1 = ways[1][index];

  assign hitWay0 = entry0.valid && (entry0.tag == reqTag);
  assign hitWay1 = entry1.valid && (entry1.tag == reqTag);

  // An empty way is replaced first, way 0 before way 1
  always_comb begin
    if (!entry0.valid) begin
      lruWay = 1'b0;
    end else if (!entry1.valid) begin
      lruWay = 1'b1;
    end else begin
      lruWay = lruBits[index];
    end
  end

  assign victimEntry = wayEn ? entry1 : entry0;

endmodule

// File: cacheDataArray.sv
`include "cache_defines.svh"

module cacheDataArray (
  input  logic                         clk,
  input  logic [`CACHE_INDEX_BITS-1:0] index,
  input  logic [`CACHE_WORD_BITS-1:0]  wordIdx,
  input  logic                         wayEn,
  input  logic                         dataWe,
  input  logic                         fillSel,
  input  logic [`CACHE_DATA_BITS-1:0]  busRdata,
  input  cachePkg::cpuReq_t            cpuReq,
  output logic [`CACHE_DATA_BITS-1:0]  rdata,
  output logic [`CACHE_DATA_BITS-1:0]  victimWord
);

  logic [`CACHE_DATA_BITS-1:0] mem [2][`CACHE_SETS][`CACHE_WORDS_PER_BLOCK];
  logic [`CACHE_DATA_BITS-1:0] writeWord;
  logic [`CACHE_WORD_BITS-1:0] reqWord;

  assign reqWord = cpuReq.addr[`CACHE_INDEX_LSB-1:`CACHE_BYTE_BITS];

  // Fill word from the bus or store data from the processor
  assign writeWord = fillSel ? busRdata : cpuReq.wdata;

  always_ff @(posedge clk) begin
    if (dataWe) begin
      mem[wayEn][index][wordIdx] <= writeWord;
    end
  end

  // Processor read uses the request's own word offset
  assign rdata = mem[wayEn][index][reqWord];

  // Write-back read follows the block word counter
  assign victimWord = mem[wayEn][index][wordIdx];

endmodule

// File: apbMaster.sv
`include "cache_defines.svh"

module apbMaster (
  input  logic                        clk,
  input  logic                        reset,
  input  cachePkg::busCmd_t           busCmd,
  output logic                        busDone,
  output logic [`CACHE_DATA_BITS-1:0] busRdata,
  output logic                        psel,
  output logic                        penable,
  output logic                        pwrite,
  output logic [`CACHE_ADDR_BITS-1:0] paddr,
  output logic [`CACHE_DATA_BITS-1:0] pwdata,
  input  logic [`CACHE_DATA_BITS-1:0] prdata,
  input  logic                        pready
);

  cachePkg::apbState_t state;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= cachePkg::ApbIdle;
    end else begin
      case (state)
        cachePkg::ApbIdle:   if (busCmd.start) state <= cachePkg::ApbSetup;
        cachePkg::ApbSetup:  state <= cachePkg::ApbAccess;
        cachePkg::ApbAccess: if (pready) state <= cachePkg::ApbIdle;
        default:             state <= cachePkg::ApbIdle;
      endcase
    end
  end

  // Command held for the whole transfer
  always_ff @(posedge clk) begin
    if (state == cachePkg::ApbIdle && busCmd.start) begin
      pwrite <= busCmd.write;
      paddr  <= busCmd.addr;
      pwdata <= busCmd.wdata;
    end
  end

  assign psel     = (state != cachePkg::ApbIdle);
  assign penable  = (state == cachePkg::ApbAccess);
  assign busDone  = penable && pready;
  assign busRdata = prdata;

  // A new command only arrives between transfers
  startOnlyWhenIdle: assert property (
    @(posedge clk) disable iff (reset)
    busCmd.start |-> (state == cachePkg::ApbIdle)
  );

  // Wait states freeze the access phase
  heldDuringWait: assert property (
    @(posedge clk) disable iff (reset)
    (penable && !pready) |=> penable && $stable(paddr) && $stable(pwrite) && $stable(pwdata)
  );

endmodule

// File: dataCache.sv
`include "cache_defines.svh"

module dataCache (
  input  logic                        clk,
  input  logic                        reset,
  input  cachePkg::cpuReq_t           cpuReq,
  output logic [`CACHE_DATA_BITS-1:0] rdata,
  output logic                        stall,
  output logic                        psel,
  output logic                        penable,
  output logic                        pwrite,
  output logic [`CACHE_ADDR_BITS-1:0] paddr,
  output logic [`CACHE_DATA_BITS-1:0] pwdata,
  input  logic [`CACHE_DATA_BITS-1:0] prdata,
  input  logic                        pready
);

  logic hitWay0;
  logic hitWay1;
  logic lruWay;
  logic wayEn;
  logic tagWe;
  logic setDirty;
  logic touch;
  logic dataWe;
  logic fillSel;
  logic busDone;
  logic [`CACHE_WORD_BITS-1:0] wordIdx;
  logic [`CACHE_DATA_BITS-1:0] victimWord;
  logic [`CACHE_DATA_BITS-1:0] busRdata;
  cachePkg::tagEntry_t victimEntry;
  cachePkg::tagEntry_t newEntry;
  cachePkg::busCmd_t busCmd;

  cacheController controller (
    .clk, .reset, .cpuReq, .hitWay0, .hitWay1, .lruWay, .victimEntry, .victimWord,
    .busDone, .stall, .wayEn, .tagWe, .newEntry, .setDirty, .touch, .dataWe, .fillSel,
    .wordIdx, .busCmd
  );

  cacheTagArray tagArray (
    .clk, .reset,
    .index  (cpuReq.addr[`CACHE_TAG_LSB-1:`CACHE_INDEX_LSB]),
    .reqTag (cpuReq.addr[`CACHE_ADDR_BITS-1:`CACHE_TAG_LSB]),
    .wayEn, .tagWe, .newEntry, .setDirty, .touch, .hitWay0, .hitWay1, .lruWay, .victimEntry
  );

  cacheDataArray dataArray (
    .clk,
    .index (cpuReq.addr[`CACHE_TAG_LSB-1:`CACHE_INDEX_LSB]),
    .wordIdx, .wayEn, .dataWe, .fillSel, .busRdata, .cpuReq, .rdata, .victimWord
  );

  apbMaster bus (
    .clk, .reset, .busCmd, .busDone, .busRdata,
    .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready
  );

endmodule

// File: tbClock.sv
module tbClock #(
  parameter int periodNs = 100,
  parameter int resetCycles = 8
) (
  output logic clk,
  output logic reset
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #(periodNs / 2) clk = ~clk;
  end

  // Reset released a little after the last reset edge
  initial begin
    reset = 1'b1;
    repeat (resetCycles) @(posedge clk);
    #10 reset = 1'b0;
  end

endmodule

// File: tbDataCache.sv
`include "cache_defines.svh"

module tbDataCache;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int clockPeriod = 100;
  localparam int driveDelay = 10;
  localparam int randomCount = 300;
  localparam int sweepCount = 3 * `CACHE_SETS * `CACHE_WORDS_PER_BLOCK;
  localparam int timeoutCycles = 8 + (randomCount + sweepCount) * 40;

  logic clk;
  logic reset;
  cachePkg::cpuReq_t cpuReq;
  logic [`CACHE_DATA_BITS-1:0] rdata;
  logic stall;
  logic psel;
  logic penable;
  logic pwrite;
  logic [`CACHE_ADDR_BITS-1:0] paddr;
  logic [`CACHE_DATA_BITS-1:0] pwdata;
  logic [`CACHE_DATA_BITS-1:0] prdata;
  logic pready;

  // Memory contents as the processor should see them
  logic [31:0] refMem [256];
  logic modelValid [2][`CACHE_SETS];
  logic modelDirty [2][`CACHE_SETS];
  int modelTag [2][`CACHE_SETS];
  logic modelLru [`CACHE_SETS];
  // Completed APB transfers as the slave model saw them
  cachePkg::busCmd_t transfers[$];
  logic [31:0] reqRng;
  int checkCount = 0;
  int errorCount = 0;

  tbClock #(.periodNs(clockPeriod), .resetCycles(8)) clockGen (.clk, .reset);

  dataCache DUT (
    .clk, .reset, .cpuReq, .rdata, .stall,
    .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready
  );

  function automatic logic [31:0] nextRandom(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] fillWord(input int i);
    return 32'hD000_0000 ^ (32'(i) * 32'h0001_0101);
  endfunction

  function automatic logic [31:0] makeAddr(input int tagV, input int setV, input int wordV);
    return (32'(tagV) << `CACHE_TAG_LSB) | (32'(setV) << `CACHE_INDEX_LSB) |
           (32'(wordV) << `CACHE_BYTE_BITS);
  endfunction

  function automatic logic [7:0] memIndex(input logic [31:0] addr);
    return addr[9:2];
  endfunction

  task automatic compareWord(input string name, input logic [`CACHE_DATA_BITS-1:0] expected,
                             input logic [`CACHE_DATA_BITS-1:0] actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic compareBit(input string name, input logic expected, input logic actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("Mismatch at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
    end
  endtask

  task automatic compareBus(input string name, input cachePkg::busCmd_t expected,
                            input cachePkg::busCmd_t actual);
    checkCount++;
    if (actual.write !== expected.write || actual.addr !== expected.addr) begin
      errorCount++;
      $display("Mismatch at %0t ns: %s expected write=%b addr=%h, got write=%b addr=%h",
               $time, name, expected.write, expected.addr, actual.write, actual.addr);
    end
  endtask

  // Predict one processor access in the model and check the DUT against it
  task automatic doAccess(input logic isWrite, input int tagV, input int setV,
                          input int wordV, input logic [31:0] wdata);
    cachePkg::busCmd_t expected[$];
    cachePkg::busCmd_t cmd;
    logic [31:0] addr;
    logic hit;
    int way;
    int k;
    addr = makeAddr(tagV, setV, wordV);
    hit = 1'b1;
    cmd = '0;
    cmd.start = 1'b1;
    if (modelValid[0][setV] && modelTag[0][setV] == tagV) begin
      way = 0;
    end else if (modelValid[1][setV] && modelTag[1][setV] == tagV) begin
      way = 1;
    end else begin
      hit = 1'b0;
      if (!modelValid[0][setV]) way = 0;
      else if (!modelValid[1][setV]) way = 1;
      else way = int'(modelLru[setV]);
      if (modelValid[way][setV] && modelDirty[way][setV]) begin
        for (k = 0; k < `CACHE_WORDS_PER_BLOCK; k++) begin
          cmd.write = 1'b1;
          cmd.addr = makeAddr(modelTag[way][setV], setV, k);
          cmd.wdata = refMem[memIndex(cmd.addr)];
          expected.push_back(cmd);
        end
      end
      for (k = 0; k < `CACHE_WORDS_PER_BLOCK; k++) begin
        cmd.write = 1'b0;
        cmd.addr = makeAddr(tagV, setV, k);
        cmd.wdata = '0;
        expected.push_back(cmd);
      end
    end
    transfers.delete();
    cpuReq.read = ~isWrite;
    cpuReq.write = isWrite;
    cpuReq.addr = addr;
    cpuReq.wdata = wdata;
    @(negedge clk);
    compareBit("stall", ~hit, stall);
    while (stall === 1'b1) @(negedge clk);
    if (!isWrite) compareWord("rdata", refMem[memIndex(addr)], rdata);
    if (transfers.size() != expected.size()) begin
      errorCount++;
      $display("Error at %0t ns: access to %h expected %0d APB transfers but saw %0d",
               $time, addr, expected.size(), transfers.size());
    end else begin
      for (k = 0; k < expected.size(); k++) begin
        compareBus("APB transfer", expected[k], transfers[k]);
        if (expected[k].write) compareWord("pwdata", expected[k].wdata, transfers[k].wdata);
      end
    end
    if (!hit) begin
      modelValid[way][setV] = 1'b1;
      modelDirty[way][setV] = 1'b0;
      modelTag[way][setV] = tagV;
    end
    if (isWrite) begin
      modelDirty[way][setV] = 1'b1;
      refMem[memIndex(addr)] = wdata;
    end
    modelLru[setV] = (way == 0);
    @(posedge clk);
    #driveDelay;
  endtask

  task automatic reportTest(input string name, input int checksBefore, input int errorsBefore);
    $display("Test %s finished: %0d checks, %0d errors", name,
             checkCount - checksBefore, errorCount - errorsBefore);
  endtask

  // APB slave with 0 to 3 wait states per transfer
  initial begin : apbSlave
    logic [31:0] apbMem [256];
    cachePkg::busCmd_t setupCmd;
    cachePkg::busCmd_t liveCmd;
    logic [31:0] waitRng;
    int waitLeft;
    int i;
    prdata = '0;
    pready = 1'b0;
    for (i = 0; i < 256; i++) apbMem[i] = fillWord(i);
    waitRng = 32'd18057;
    waitLeft = 0;
    setupCmd = '0;
    forever begin
      @(posedge clk);
      #driveDelay;
      liveCmd = '{start: 1'b1, write: pwrite, addr: paddr, wdata: pwdata};
      if (psel && penable) begin
        compareBus("paddr and pwrite in access", setupCmd, liveCmd);
        if (setupCmd.write) compareWord("pwdata in access", setupCmd.wdata, pwdata);
        if (waitLeft > 0) begin
          waitLeft--;
          pready = 1'b0;
        end else begin
          pready = 1'b1;
          if (pwrite) apbMem[memIndex(paddr)] = pwdata;
          else prdata = apbMem[memIndex(paddr)];
          transfers.push_back(liveCmd);
        end
      end else if (psel) begin
        setupCmd = liveCmd;
        waitRng = nextRandom(waitRng);
        waitLeft = int'(waitRng[1:0]);
        pready = 1'b0;
      end else begin
        pready = 1'b0;
      end
    end
  end

  initial begin : watchdog
    #(timeoutCycles * clockPeriod);
    $display("Error: watchdog expired after %0d cycles, the run did not finish", timeoutCycles);
    $display("Done: errors found");
    $finish;
  end

  initial begin : mainSequence
    int checksBefore;
    int errorsBefore;
    int n;
    int s;
    int w;
    int t;
    cpuReq = '0;
    reqRng = 32'd18057;
    for (n = 0; n < 256; n++) refMem[n] = fillWord(n);
    for (s = 0; s < `CACHE_SETS; s++) begin
      modelValid[0][s] = 1'b0;
      modelValid[1][s] = 1'b0;
      modelDirty[0][s] = 1'b0;
      modelDirty[1][s] = 1'b0;
      modelTag[0][s] = 0;
      modelTag[1][s] = 0;
      modelLru[s] = 1'b0;
    end

    checksBefore = checkCount;
    errorsBefore = errorCount;
    wait (reset === 1'b0);
    @(negedge clk);
    compareBit("psel", 1'b0, psel);
    compareBit("penable", 1'b0, penable);
    compareBit("stall", 1'b0, stall);
    reportTest("reset", checksBefore, errorsBefore);
    @(posedge clk);
    #driveDelay;

    // Three tags per set force conflicts and dirty evictions
    checksBefore = checkCount;
    errorsBefore = errorCount;
    for (n = 0; n < randomCount; n++) begin
      reqRng = nextRandom(reqRng);
      t = int'(reqRng[31:20]) % 3;
      s = int'(reqRng[7:4]);
      w = int'(reqRng[9:8]);
      doAccess(reqRng[16], t, s, w, nextRandom(reqRng ^ 32'h5555_AAAA));
    end
    reportTest("random accesses", checksBefore, errorsBefore);

    checksBefore = checkCount;
    errorsBefore = errorCount;
    for (t = 0; t < 3; t++) begin
      for (s = 0; s < `CACHE_SETS; s++) begin
        for (w = 0; w < `CACHE_WORDS_PER_BLOCK; w++) doAccess(1'b0, t, s, w, '0);
      end
    end
    reportTest("read sweep", checksBefore, errorsBefore);
    cpuReq = '0;

    $display("Totals: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+.
cachePkg.sv
cacheController.sv
cacheTagArray.sv
cacheDataArray.sv
apbMaster.sv
dataCache.sv
tbClock.sv
tbDataCache.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
logFile=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f --top-module tbDataCache
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/VtbDataCache > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "Done: errors found" "$logFile"; then
  echo "Simulation reported errors"
  exit 1
fi
exit 0
